// File: common/csr_index_cfg.svh
// Compile-time sizes; CFG_RECORD_W must be kept in step with the field order of record_t
`ifndef CSR_INDEX_CFG_SVH
`define CSR_INDEX_CFG_SVH

// --------------------
// Word and field widths
// --------------------
`define CFG_DATA_W      32
`define CFG_ADDR_W      64
`define CFG_OFFSET_W    16
`define CFG_SHIFT_W     5

// Sequence words per engine configuration
`define CFG_SEQ_WORDS   9

// --------------------
// FIFO sizing
// --------------------
`define CFG_FIFO_DEPTH  16

// Leaves headroom for words still in flight when prog_full rises
`define CFG_FIFO_PROG   8

// Flags, three words, granularity with direction, command, buffer kind,
// pointer and size
`define CFG_RECORD_W    (4 + 3 * `CFG_DATA_W + `CFG_DATA_W + 2 + 3 + `CFG_ADDR_W + `CFG_DATA_W)

`endif

// File: common/csr_index_pkg.sv
// Enum encodings have to match the values the host writes into the setup words
`default_nettype none
`include "csr_index_cfg.svh"

package csr_index_pkg;

    // --------------------
    // Vector types
    // --------------------
    typedef logic [`CFG_DATA_W-1:0]   word_t;
    typedef logic [`CFG_OFFSET_W-1:0] offset_t;
    typedef logic [`CFG_SHIFT_W-1:0]  shift_t;
    typedef logic [`CFG_ADDR_W-1:0]   addr_t;

    // Position relative to the start of this engine's window
    typedef logic [$clog2(`CFG_SEQ_WORDS)-1:0] seq_index_t;
    typedef logic [`CFG_SEQ_WORDS-1:0]         seq_mask_t;

    // Top bit of the granularity word carries the shift direction
    typedef logic [`CFG_DATA_W-2:0] granularity_t;

    // --------------------
    // Encodings
    // --------------------
    typedef enum logic [2:0] {
        BUF_INVALID      = 3'd0,
        BUF_CU_SETUP     = 3'd1,
        BUF_ENGINE_SETUP = 3'd2,
        BUF_VERTEX_DATA  = 3'd3
    } buffer_kind_e;

    typedef enum logic [1:0] {
        CMD_INVALID = 2'd0,
        CMD_READ    = 2'd1,
        CMD_WRITE   = 2'd2
    } mem_cmd_e;

    // Field order from the MSB down is increment, decrement, mode_sequence,
    // mode_buffer, index_start, index_end, stride, granularity, shift_direction,
    // cmd, buffer, array_pointer, array_size
    typedef logic [`CFG_RECORD_W-1:0] record_t;

endpackage

`default_nettype wire

// File: hdl/sync_fifo.sv
// Single clock; a write while full is dropped and rd_data only holds meaning with rd_valid
`default_nettype none
`timescale 1ns/1ps

module sync_fifo #(
    parameter int width     = 8,
    parameter int depth     = 16,
    parameter int threshold = 8
) (
    input  logic             ap_clk,
    input  logic             areset_csr_index_generator,
    input  logic             wr_en,
    input  logic [width-1:0] wr_data,
    input  logic             rd_en,
    output logic [width-1:0] rd_data,
    output logic             rd_valid,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             wr_ok;
    logic             rd_ok;

    assign wr_ok     = wr_en & ~full;
    assign rd_ok     = rd_en & ~empty;
    assign empty     = (count == '0);
    assign full      = (count == (ptr_w+1)'(depth));
    assign prog_full = (count >= (ptr_w+1)'(threshold));

    // --------------------
    // Pointers and count
    // --------------------
    // Wrap at depth, which need not be a power of two
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count    <= count + (ptr_w+1)'(wr_ok) - (ptr_w+1)'(rd_ok);
            rd_valid <= rd_ok;
        end
    end

    // Storage and read register
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
        if (rd_ok) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // Writer has to respect full
    assert property (@(posedge ap_clk) disable iff (areset_csr_index_generator)
        wr_en |-> !full);

endmodule

`default_nettype wire

// File: csr_index_configure/config_word_filter.sv
// Words of another kind or outside this engine's window are dropped without any notice
`default_nettype none
`timescale 1ns/1ps
`include "csr_index_cfg.svh"

module config_word_filter #(
    parameter int engine_slot = 0
) (
    input  logic                        ap_clk,
    input  logic                        areset_csr_index_generator,
    input  logic                        resp_valid,
    input  csr_index_pkg::buffer_kind_e resp_buffer,
    input  csr_index_pkg::offset_t      resp_offset,
    input  csr_index_pkg::shift_t       resp_shift,
    input  csr_index_pkg::word_t        resp_data,
    output logic                        word_push,
    output csr_index_pkg::seq_index_t   word_index,
    output csr_index_pkg::word_t        word_data
);

    import csr_index_pkg::*;

    // Window of sequence positions owned by this engine
    localparam offset_t seq_lo    = offset_t'(`CFG_SEQ_WORDS * engine_slot);
    localparam offset_t seq_words = offset_t'(`CFG_SEQ_WORDS);

    logic         valid_q;
    buffer_kind_e buffer_q;
    offset_t      offset_q;
    shift_t       shift_q;
    offset_t      seq;
    offset_t      seq_rel;
    logic         kind_ok;
    logic         in_window;

    // --------------------
    // Input register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= resp_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        buffer_q  <= resp_buffer;
        offset_q  <= resp_offset;
        shift_q   <= resp_shift;
        word_data <= resp_data;
    end

    // --------------------
    // Kind and window check
    // --------------------
    assign seq       = offset_q >> shift_q;
    assign seq_rel   = seq - seq_lo;
    assign kind_ok   = (buffer_q == BUF_CU_SETUP) || (buffer_q == BUF_ENGINE_SETUP);
    assign in_window = (seq >= seq_lo) && (seq_rel < seq_words);

    // Pushed in the cycle after sampling
    assign word_push  = valid_q & kind_ok & in_window;
    assign word_index = seq_rel[$bits(seq_index_t)-1:0];

endmodule

`default_nettype wire

// File: csr_index_configure/config_assembler.sv
// Repeated positions overwrite their field; fields persist across records and only the mask clears
`default_nettype none
`timescale 1ns/1ps

module config_assembler (
    input  logic                      ap_clk,
    input  logic                      areset_csr_index_generator,
    input  logic                      word_empty,
    input  logic                      word_valid,
    input  csr_index_pkg::seq_index_t word_index,
    input  csr_index_pkg::word_t      word_data,
    input  logic                      record_full,
    output logic                      word_rd_en,
    output logic                      record_push,
    output csr_index_pkg::record_t    record
);

    import csr_index_pkg::*;

    logic         increment_q;
    logic         decrement_q;
    logic         mode_sequence_q;
    logic         mode_buffer_q;
    word_t        index_start_q;
    word_t        index_end_q;
    word_t        stride_q;
    granularity_t granularity_q;
    logic         shift_direction_q;
    mem_cmd_e     cmd_q;
    buffer_kind_e buffer_q;
    addr_t        array_pointer_q;
    word_t        array_size_q;
    seq_mask_t    seen_q;
    logic         set_done;

    assign set_done = &seen_q;

    // Hold off while a record is pending or the output side is backing up
    assign word_rd_en = ~word_empty & ~set_done & ~record_full;

    // --------------------
    // Field decode
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            increment_q       <= 1'b0;
            decrement_q       <= 1'b0;
            mode_sequence_q   <= 1'b0;
            mode_buffer_q     <= 1'b0;
            index_start_q     <= '0;
            index_end_q       <= '0;
            stride_q          <= '0;
            granularity_q     <= '0;
            shift_direction_q <= 1'b0;
            cmd_q             <= CMD_INVALID;
            buffer_q          <= BUF_INVALID;
            array_pointer_q   <= '0;
            array_size_q      <= '0;
        end else if (word_valid) begin
            case (word_index)
                seq_index_t'(0): begin
                    increment_q     <= word_data[0];
                    decrement_q     <= word_data[1];
                    mode_sequence_q <= word_data[2];
                    mode_buffer_q   <= word_data[3];
                end
                seq_index_t'(1): index_start_q <= word_data;
                seq_index_t'(2): index_end_q <= word_data;
                seq_index_t'(3): stride_q <= word_data;
                seq_index_t'(4): begin
                    granularity_q     <= word_data[$bits(granularity_t)-1:0];
                    shift_direction_q <= word_data[$bits(word_t)-1];
                end
                seq_index_t'(5): begin
                    cmd_q    <= mem_cmd_e'(word_data[1:0]);
                    buffer_q <= buffer_kind_e'(word_data[4:2]);
                end
                // Pointer arrives low half first
                seq_index_t'(6): array_pointer_q[$bits(word_t)-1:0] <= word_data;
                seq_index_t'(7): array_pointer_q[$bits(addr_t)-1:$bits(word_t)] <= word_data;
                seq_index_t'(8): array_size_q <= word_data;
                default: ;
            endcase
        end
    end

    // --------------------
    // Seen mask and record
    // --------------------
    // A word landing while the set is done already belongs to the next set
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            seen_q      <= '0;
            record_push <= 1'b0;
        end else begin
            seen_q      <= (set_done ? '0 : seen_q) |
                           (word_valid ? seq_mask_t'(1) << word_index : '0);
            record_push <= set_done;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (set_done) begin
            record <= {increment_q, decrement_q, mode_sequence_q, mode_buffer_q,
                       index_start_q, index_end_q, stride_q, granularity_q,
                       shift_direction_q, cmd_q, buffer_q, array_pointer_q,
                       array_size_q};
        end
    end

    // Response FIFO answers only the pops issued here
    assert property (@(posedge ap_clk) disable iff (areset_csr_index_generator)
        word_valid |-> $past(word_rd_en));

endmodule

`default_nettype wire

// File: csr_index_configure/csr_index_configure.sv
// No ready on the response side so the source must stop resp_valid while resp_prog_full is high
`default_nettype none
`timescale 1ns/1ps
`include "csr_index_cfg.svh"

module csr_index_configure #(
    parameter int engine_slot = 0
) (
    input  logic                        ap_clk,
    input  logic                        areset_csr_index_generator,
    input  logic                        resp_valid,
    input  csr_index_pkg::buffer_kind_e resp_buffer,
    input  csr_index_pkg::offset_t      resp_offset,
    input  csr_index_pkg::shift_t       resp_shift,
    input  csr_index_pkg::word_t        resp_data,
    input  logic                        cfg_rd_en,
    output logic                        resp_prog_full,
    output logic                        cfg_valid,
    output logic                        cfg_increment,
    output logic                        cfg_decrement,
    output logic                        cfg_mode_sequence,
    output logic                        cfg_mode_buffer,
    output csr_index_pkg::word_t        cfg_index_start,
    output csr_index_pkg::word_t        cfg_index_end,
    output csr_index_pkg::word_t        cfg_stride,
    output csr_index_pkg::granularity_t cfg_granularity,
    output logic                        cfg_shift_direction,
    output csr_index_pkg::mem_cmd_e     cfg_cmd,
    output csr_index_pkg::buffer_kind_e cfg_buffer,
    output csr_index_pkg::addr_t        cfg_array_pointer,
    output csr_index_pkg::word_t        cfg_array_size
);

    import csr_index_pkg::*;

    // Response FIFO entry is the window index on top of the data word
    localparam int entry_w = $bits(seq_index_t) + `CFG_DATA_W;

    logic               word_push;
    seq_index_t         word_index;
    word_t              word_data;
    logic               word_rd_en;
    logic               word_valid;
    logic               word_empty;
    logic [entry_w-1:0] word_entry;
    seq_index_t         fifo_index;
    word_t              fifo_data;
    logic               record_push;
    record_t            record;
    logic               record_full;
    logic               record_valid;
    record_t            record_data;
    logic [1:0]         cmd_q;
    logic [2:0]         buffer_q;

    // --------------------
    // Input side
    // --------------------
    config_word_filter #(
        .engine_slot (engine_slot)
    ) word_filter (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .resp_valid                 (resp_valid),
        .resp_buffer                (resp_buffer),
        .resp_offset                (resp_offset),
        .resp_shift                 (resp_shift),
        .resp_data                  (resp_data),
        .word_push                  (word_push),
        .word_index                 (word_index),
        .word_data                  (word_data)
    );

    sync_fifo #(
        .width     (entry_w),
        .depth     (`CFG_FIFO_DEPTH),
        .threshold (`CFG_FIFO_PROG)
    ) resp_fifo (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .wr_en                      (word_push),
        .wr_data                    ({word_index, word_data}),
        .rd_en                      (word_rd_en),
        .rd_data                    (word_entry),
        .rd_valid                   (word_valid),
        .empty                      (word_empty),
        .full                       (),
        .prog_full                  (resp_prog_full)
    );

    assign {fifo_index, fifo_data} = word_entry;

    config_assembler assembler (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .word_empty                 (word_empty),
        .word_valid                 (word_valid),
        .word_index                 (fifo_index),
        .word_data                  (fifo_data),
        .record_full                (record_full),
        .word_rd_en                 (word_rd_en),
        .record_push                (record_push),
        .record                     (record)
    );

    // --------------------
    // Output side
    // --------------------
    // Reads on an empty FIFO are ignored, so cfg_rd_en goes straight in
    sync_fifo #(
        .width     ($bits(record_t)),
        .depth     (`CFG_FIFO_DEPTH),
        .threshold (`CFG_FIFO_PROG)
    ) record_fifo (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .wr_en                      (record_push),
        .wr_data                    (record),
        .rd_en                      (cfg_rd_en),
        .rd_data                    (record_data),
        .rd_valid                   (record_valid),
        .empty                      (),
        .full                       (),
        .prog_full                  (record_full)
    );

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            cfg_valid <= 1'b0;
        end else begin
            cfg_valid <= record_valid;
        end
    end

    // Split the record into the cfg ports
    always_ff @(posedge ap_clk) begin
        {cfg_increment, cfg_decrement, cfg_mode_sequence, cfg_mode_buffer,
         cfg_index_start, cfg_index_end, cfg_stride, cfg_granularity,
         cfg_shift_direction, cmd_q, buffer_q, cfg_array_pointer,
         cfg_array_size} <= record_data;
    end

    assign cfg_cmd    = mem_cmd_e'(cmd_q);
    assign cfg_buffer = buffer_kind_e'(buffer_q);

    // Source keeps quiet once the response FIFO crosses its threshold
    assert property (@(posedge ap_clk) disable iff (areset_csr_index_generator)
        resp_prog_full |-> !resp_valid);

endmodule

`default_nettype wire

// File: verification/tb_csr_index_configure.sv
// Drives engine slot 1 only and keeps resp_valid low whenever resp_prog_full is high
`default_nettype none
`timescale 1ns/1ps
`include "csr_index_cfg.svh"

module tb_csr_index_configure;

    import csr_index_pkg::*;

    localparam int engine_slot = 1;
    localparam int seq_base    = `CFG_SEQ_WORDS * engine_slot;
    // About 75 words plus drain gaps, so this limit leaves a wide margin
    localparam int timeout_cycles = 20000;

    typedef struct packed {
        logic         increment;
        logic         decrement;
        logic         mode_sequence;
        logic         mode_buffer;
        word_t        index_start;
        word_t        index_end;
        word_t        stride;
        granularity_t granularity;
        logic         shift_direction;
        logic [1:0]   cmd;
        logic [2:0]   buffer;
        addr_t        array_pointer;
        word_t        array_size;
    } cfg_rec_t;

    logic         ap_clk = 1'b0;
    logic         areset_csr_index_generator;
    logic         resp_valid;
    buffer_kind_e resp_buffer;
    offset_t      resp_offset;
    shift_t       resp_shift;
    word_t        resp_data;
    logic         cfg_rd_en = 1'b0;
    logic         resp_prog_full;
    logic         cfg_valid;
    logic         cfg_increment;
    logic         cfg_decrement;
    logic         cfg_mode_sequence;
    logic         cfg_mode_buffer;
    word_t        cfg_index_start;
    word_t        cfg_index_end;
    word_t        cfg_stride;
    granularity_t cfg_granularity;
    logic         cfg_shift_direction;
    mem_cmd_e     cfg_cmd;
    buffer_kind_e cfg_buffer;
    addr_t        cfg_array_pointer;
    word_t        cfg_array_size;

    // Model state persists across records like the DUT fields
    logic [`CFG_SEQ_WORDS-1:0][`CFG_DATA_W-1:0] last_words = '0;
    seq_mask_t   seen_model  = '0;
    cfg_rec_t    exp_q[$];
    logic [31:0] lfsr_state  = 32'hfc7f4721;
    logic        hold_output = 1'b0;
    int          error_count  = 0;
    int          record_count = 0;
    int          test_count   = 0;
    int          cycle_count  = 0;

    csr_index_configure #(
        .engine_slot (engine_slot)
    ) dut0 (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .resp_valid                 (resp_valid),
        .resp_buffer                (resp_buffer),
        .resp_offset                (resp_offset),
        .resp_shift                 (resp_shift),
        .resp_data                  (resp_data),
        .cfg_rd_en                  (cfg_rd_en),
        .resp_prog_full             (resp_prog_full),
        .cfg_valid                  (cfg_valid),
        .cfg_increment              (cfg_increment),
        .cfg_decrement              (cfg_decrement),
        .cfg_mode_sequence          (cfg_mode_sequence),
        .cfg_mode_buffer            (cfg_mode_buffer),
        .cfg_index_start            (cfg_index_start),
        .cfg_index_end              (cfg_index_end),
        .cfg_stride                 (cfg_stride),
        .cfg_granularity            (cfg_granularity),
        .cfg_shift_direction        (cfg_shift_direction),
        .cfg_cmd                    (cfg_cmd),
        .cfg_buffer                 (cfg_buffer),
        .cfg_array_pointer          (cfg_array_pointer),
        .cfg_array_size             (cfg_array_size)
    );

    always #50 ap_clk = ~ap_clk;

    // --------------------
    // Random source
    // --------------------
    // Taps 32, 22, 2, 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // --------------------
    // Reference model
    // --------------------
    function automatic cfg_rec_t expected_record(
        input logic [`CFG_SEQ_WORDS-1:0][`CFG_DATA_W-1:0] w
    );
        cfg_rec_t r;
        r.increment       = w[0][0];
        r.decrement       = w[0][1];
        r.mode_sequence   = w[0][2];
        r.mode_buffer     = w[0][3];
        r.index_start     = w[1];
        r.index_end       = w[2];
        r.stride          = w[3];
        r.granularity     = w[4][30:0];
        r.shift_direction = w[4][31];
        r.cmd             = w[5][1:0];
        r.buffer          = w[5][4:2];
        r.array_pointer   = {w[7], w[6]};
        r.array_size      = w[8];
        return r;
    endfunction

    function automatic logic word_kept(input buffer_kind_e kind, input offset_t offset,
                                       input shift_t shift);
        int seq;
        seq = int'(offset >> shift);
        return (kind == BUF_CU_SETUP || kind == BUF_ENGINE_SETUP) &&
               seq >= seq_base && seq < seq_base + `CFG_SEQ_WORDS;
    endfunction

    // --------------------
    // Stimulus
    // --------------------
    task automatic send_word(input buffer_kind_e kind, input offset_t offset,
                             input shift_t shift, input word_t data);
        int pos;
        @(posedge ap_clk);
        #5;
        while (resp_prog_full) begin
            resp_valid = 1'b0;
            @(posedge ap_clk);
            #5;
        end
        resp_valid  = 1'b1;
        resp_buffer = kind;
        resp_offset = offset;
        resp_shift  = shift;
        resp_data   = data;
        if (word_kept(kind, offset, shift)) begin
            pos = int'(offset >> shift) - seq_base;
            last_words[pos] = data;
            seen_model[pos] = 1'b1;
            if (&seen_model) begin
                exp_q.push_back(expected_record(last_words));
                seen_model = '0;
            end
        end
    endtask

    // Low offset bits below the shift are random and must not matter
    task automatic send_position(input buffer_kind_e kind, input shift_t shift,
                                 input int pos, input word_t data);
        offset_t offset;
        offset = offset_t'(seq_base + pos) << shift;
        offset = offset | offset_t'(rand_bits(int'(shift)));
        send_word(kind, offset, shift, data);
    endtask

    task automatic go_idle();
        @(posedge ap_clk);
        #5;
        resp_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(posedge ap_clk);
        end
        // Room for a stray extra record to show up
        repeat (10) @(posedge ap_clk);
    endtask

    task automatic report_test(input string name, input int err0, input int rec0);
        test_count++;
        $display("Test %0d %s: %0d records, %0d errors", test_count, name,
                 record_count - rec0, error_count - err0);
    endtask

    task automatic expect_records(input int rec0, input int want);
        if (record_count - rec0 != want) begin
            $display("Expected %0d records but %0d arrived", want, record_count - rec0);
            error_count++;
        end
    endtask

    // --------------------
    // Checking
    // --------------------
    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_record();
        cfg_rec_t e;
        record_count++;
        if (exp_q.size() == 0) begin
            $display("A record arrived on cfg_valid although no complete set was sent");
            error_count++;
        end else begin
            e = exp_q.pop_front();
            compare_field("cfg_increment", 64'(cfg_increment), 64'(e.increment));
            compare_field("cfg_decrement", 64'(cfg_decrement), 64'(e.decrement));
            compare_field("cfg_mode_sequence", 64'(cfg_mode_sequence), 64'(e.mode_sequence));
            compare_field("cfg_mode_buffer", 64'(cfg_mode_buffer), 64'(e.mode_buffer));
            compare_field("cfg_index_start", 64'(cfg_index_start), 64'(e.index_start));
            compare_field("cfg_index_end", 64'(cfg_index_end), 64'(e.index_end));
            compare_field("cfg_stride", 64'(cfg_stride), 64'(e.stride));
            compare_field("cfg_granularity", 64'(cfg_granularity), 64'(e.granularity));
            compare_field("cfg_shift_direction", 64'(cfg_shift_direction),
                          64'(e.shift_direction));
            compare_field("cfg_cmd", 64'(cfg_cmd), 64'(e.cmd));
            compare_field("cfg_buffer", 64'(cfg_buffer), 64'(e.buffer));
            compare_field("cfg_array_pointer", cfg_array_pointer, e.array_pointer);
            compare_field("cfg_array_size", 64'(cfg_array_size), 64'(e.array_size));
        end
    endtask

    // Consumer side with outputs sampled mid-cycle
    always begin
        @(posedge ap_clk);
        #5;
        cfg_rd_en = ~hold_output & ~areset_csr_index_generator;
        @(negedge ap_clk);
        if (!areset_csr_index_generator && cfg_valid) begin
            check_record();
        end
    end

    always @(posedge ap_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout after %0d cycles, %0d expected records never arrived",
                     cycle_count, exp_q.size());
            $display("Testbench failed");
            $finish;
        end
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        int order [`CFG_SEQ_WORDS];
        int tmp;
        int j;
        int err0;
        int rec0;
        areset_csr_index_generator = 1'b1;
        resp_valid  = 1'b0;
        resp_buffer = BUF_INVALID;
        resp_offset = '0;
        resp_shift  = '0;
        resp_data   = '0;
        repeat (2) @(posedge ap_clk);
        #5;
        areset_csr_index_generator = 1'b0;

        // Quiet after reset
        err0 = error_count;
        rec0 = record_count;
        for (int i = 0; i < 20; i++) begin
            @(negedge ap_clk);
            if (cfg_valid !== 1'b0) begin
                $display("cfg_valid went high with no stimulus after reset");
                error_count++;
            end
            if (resp_prog_full !== 1'b0) begin
                $display("resp_prog_full went high with no stimulus after reset");
                error_count++;
            end
        end
        report_test("idle after reset", err0, rec0);

        // Full set in order
        err0 = error_count;
        rec0 = record_count;
        for (int p = 0; p < `CFG_SEQ_WORDS; p++) begin
            send_position(BUF_ENGINE_SETUP, shift_t'(0), p, rand_bits(32));
        end
        go_idle();
        wait_drained();
        expect_records(rec0, 1);
        report_test("in-order set", err0, rec0);

        // Shuffled with repeats and the last new position sent at the end
        err0 = error_count;
        rec0 = record_count;
        for (int i = 0; i < `CFG_SEQ_WORDS; i++) begin
            order[i] = i;
        end
        for (int i = `CFG_SEQ_WORDS - 1; i > 0; i--) begin
            j = int'(rand_bits(4)) % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 8; i++) begin
            send_position(BUF_CU_SETUP, shift_t'(2), order[i], rand_bits(32));
        end
        for (int i = 0; i < 5; i++) begin
            send_position(BUF_CU_SETUP, shift_t'(2), order[int'(rand_bits(3))], rand_bits(32));
        end
        send_position(BUF_CU_SETUP, shift_t'(2), order[8], rand_bits(32));
        go_idle();
        wait_drained();
        expect_records(rec0, 1);
        report_test("shuffled with repeats", err0, rec0);

        // Partial set mixed with words for other kinds and slots
        err0 = error_count;
        rec0 = record_count;
        for (int p = 0; p < 6; p++) begin
            send_position(BUF_ENGINE_SETUP, shift_t'(0), p, rand_bits(32));
        end
        for (int p = 6; p < `CFG_SEQ_WORDS; p++) begin
            send_position(BUF_VERTEX_DATA, shift_t'(0), p, rand_bits(32));
        end
        send_word(BUF_ENGINE_SETUP, offset_t'(3), shift_t'(0), rand_bits(32));
        send_word(BUF_CU_SETUP, offset_t'(8), shift_t'(0), rand_bits(32));
        send_word(BUF_ENGINE_SETUP, offset_t'(20), shift_t'(0), rand_bits(32));
        send_word(BUF_CU_SETUP, offset_t'(26 * 2), shift_t'(1), rand_bits(32));
        go_idle();
        repeat (30) @(posedge ap_clk);
        if (record_count != rec0) begin
            $display("A record appeared before the set was complete");
            error_count++;
        end
        for (int p = 6; p < `CFG_SEQ_WORDS; p++) begin
            send_position(BUF_CU_SETUP, shift_t'(0), p, rand_bits(32));
        end
        go_idle();
        wait_drained();
        expect_records(rec0, 1);
        report_test("filtered words", err0, rec0);

        // Four sets held in the output FIFO, then drained
        err0 = error_count;
        rec0 = record_count;
        hold_output = 1'b1;
        for (int s = 0; s < 4; s++) begin
            for (int p = 0; p < `CFG_SEQ_WORDS; p++) begin
                send_position(BUF_ENGINE_SETUP, shift_t'(0), p, rand_bits(32));
            end
        end
        go_idle();
        repeat (40) @(posedge ap_clk);
        if (record_count != rec0) begin
            $display("A record left the DUT while cfg_rd_en was held low");
            error_count++;
        end
        hold_output = 1'b0;
        wait_drained();
        expect_records(rec0, 4);
        report_test("held output drain", err0, rec0);

        if (exp_q.size() != 0) begin
            $display("%0d expected records never arrived", exp_q.size());
            error_count++;
        end
        $display("Summary: %0d tests, %0d records checked, %0d errors",
                 test_count, record_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
common/csr_index_pkg.sv
hdl/sync_fifo.sv
csr_index_configure/config_word_filter.sv
csr_index_configure/config_assembler.sv
csr_index_configure/csr_index_configure.sv
verification/tb_csr_index_configure.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds with Verilator and runs the testbench; exit status follows the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
    --top-module tb_csr_index_configure -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "Build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }

grep -qx "Testbench passed" sim.log && echo "PASS" \
    || { cat sim.log; echo "FAIL"; exit 1; }
